// ==== include/layer_consts.svh ====
`ifndef LAYER_CONSTS_SVH
`define LAYER_CONSTS_SVH

// Command words per layer command
`define CMD_WORDS       3
`define CMD_WORD_CNT_W  2
`define CMD_W           32

// Word 0 field positions
`define OP_MSB          2
`define OP_LSB          0
`define SHIFT_MSB       7
`define SHIFT_LSB       4
`define WIN_LEN_MSB     15
`define WIN_LEN_LSB     8
`define WIN_CNT_MSB     23
`define WIN_CNT_LSB     16

// Field and datapath widths
`define SHIFT_W         4
`define FIELD_W         8
`define SAMPLE_W        8
`define RESULT_W        32
`define CMD_COUNT_W     7

`endif

// ==== logic/layer_pkg.sv ====
package layer_pkg;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        // Waiting for operation enable
        SEQ_IDLE   = 3'd0,
        // Reading command words
        SEQ_FETCH  = 3'd1,
        // One cycle, fires start or skips
        SEQ_ISSUE  = 3'd2,
        // Waiting for the last result of the command
        SEQ_RUN    = 3'd3,
        // All commands done, interrupt held
        SEQ_FINISH = 3'd4
    } seq_state_e;

    // Layer opcodes from word 0
    // Unlisted codes behave like OP_IDLE
    typedef enum logic [2:0] {
        OP_IDLE      = 3'b000,
        OP_CONV_RELU = 3'b001,
        OP_MAX_POOL  = 3'b100,
        OP_AVG_POOL  = 3'b101
    } op_kind_e;

endpackage

// ==== logic/cmd_sequencer.sv ====
`include "layer_consts.svh"

module cmd_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_op_en,
    input  logic [`CMD_COUNT_W-1:0] i_cmd_count,
    input  logic                    i_cmd_we,
    input  logic [`CMD_W-1:0]       i_cmd,
    input  logic                    i_cmd_done,
    output logic                    o_cmd_rd_en,
    output logic                    o_start,
    output layer_pkg::op_kind_e     o_op,
    output logic [`SHIFT_W-1:0]     o_pool_shift,
    output logic [`FIELD_W-1:0]     o_win_len,
    output logic [`FIELD_W-1:0]     o_win_count,
    output logic [`RESULT_W-1:0]    o_base_addr,
    output logic [`RESULT_W-1:0]    o_bias,
    output logic                    o_irq
);

    // Index of the final word in a command
    localparam logic [`CMD_WORD_CNT_W-1:0] LAST_WORD = `CMD_WORD_CNT_W'(`CMD_WORDS - 1);

    layer_pkg::seq_state_e       state;
    layer_pkg::seq_state_e       next_state;
    logic [`CMD_WORD_CNT_W-1:0]  word_cnt;
    logic [`CMD_COUNT_W-1:0]     done_cnt;
    logic                        fetch_we;
    logic                        last_word;
    logic                        skip;
    logic                        cmd_finished;
    logic                        all_done;

    // Words only count while the read enable is up
    assign fetch_we  = (state == layer_pkg::SEQ_FETCH) && i_cmd_we;
    assign last_word = fetch_we && (word_cnt == LAST_WORD);

    // Unknown opcode or empty window geometry means no engine work
    assign skip = !(o_op inside {layer_pkg::OP_CONV_RELU, layer_pkg::OP_MAX_POOL,
                                 layer_pkg::OP_AVG_POOL})
                  || (o_win_len == '0) || (o_win_count == '0);

    // A command ends by combiner done or by being skipped in issue
    assign cmd_finished = ((state == layer_pkg::SEQ_RUN) && i_cmd_done)
                          || ((state == layer_pkg::SEQ_ISSUE) && skip);
    assign all_done     = ((done_cnt + 1'b1) == i_cmd_count);

    assign o_cmd_rd_en = (state == layer_pkg::SEQ_FETCH);
    assign o_start     = (state == layer_pkg::SEQ_ISSUE) && !skip;

    always_comb begin
        next_state = state;
        case (state)
            layer_pkg::SEQ_IDLE: begin
                // Empty command list finishes at once
                if (i_op_en) begin
                    next_state = (i_cmd_count == '0) ? layer_pkg::SEQ_FINISH
                                                     : layer_pkg::SEQ_FETCH;
                end
            end
            layer_pkg::SEQ_FETCH: begin
                if (last_word) begin
                    next_state = layer_pkg::SEQ_ISSUE;
                end
            end
            layer_pkg::SEQ_ISSUE: begin
                if (skip) begin
                    next_state = all_done ? layer_pkg::SEQ_FINISH : layer_pkg::SEQ_FETCH;
                end else begin
                    next_state = layer_pkg::SEQ_RUN;
                end
            end
            layer_pkg::SEQ_RUN: begin
                if (i_cmd_done) begin
                    next_state = all_done ? layer_pkg::SEQ_FINISH : layer_pkg::SEQ_FETCH;
                end
            end
            layer_pkg::SEQ_FINISH: next_state = layer_pkg::SEQ_FINISH;
            default: next_state = layer_pkg::SEQ_IDLE;
        endcase
    end

    // FSM, word counter, done count and word 0 control fields
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= layer_pkg::SEQ_IDLE;
            word_cnt    <= '0;
            done_cnt    <= '0;
            o_irq       <= 1'b0;
            o_op        <= layer_pkg::OP_IDLE;
            o_win_len   <= '0;
            o_win_count <= '0;
        end else begin
            state <= next_state;
            if (fetch_we) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
            if (cmd_finished) begin
                done_cnt <= done_cnt + 1'b1;
            end
            // Sticky until reset
            if (next_state == layer_pkg::SEQ_FINISH) begin
                o_irq <= 1'b1;
            end
            if (fetch_we && (word_cnt == '0)) begin
                o_op        <= layer_pkg::op_kind_e'(i_cmd[`OP_MSB:`OP_LSB]);
                o_win_len   <= i_cmd[`WIN_LEN_MSB:`WIN_LEN_LSB];
                o_win_count <= i_cmd[`WIN_CNT_MSB:`WIN_CNT_LSB];
            end
        end
    end

    // Payload fields, word 0 shift plus words 1 and 2
    always_ff @(posedge clk) begin
        if (fetch_we) begin
            case (word_cnt)
                2'd0: o_pool_shift <= i_cmd[`SHIFT_MSB:`SHIFT_LSB];
                2'd1: o_base_addr  <= i_cmd;
                2'd2: o_bias       <= i_cmd;
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/mac_window_engine.sv ====
`include "layer_consts.svh"

module mac_window_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_start,
    input  logic [`FIELD_W-1:0]  i_win_len,
    input  logic [`FIELD_W-1:0]  i_win_count,
    input  logic [`RESULT_W-1:0] i_bias,
    input  logic                 i_sample_we,
    input  logic [`SAMPLE_W-1:0] i_sample,
    input  logic [`SAMPLE_W-1:0] i_weight,
    output logic                 o_result_we,
    output logic [`RESULT_W-1:0] o_sum,
    output logic                 o_last
);

    logic                        armed;
    logic [`FIELD_W-1:0]         samp_cnt;
    logic [`FIELD_W-1:0]         win_cnt;
    logic signed [`RESULT_W-1:0] acc;
    logic signed [`RESULT_W-1:0] prod;
    logic signed [`RESULT_W-1:0] base;
    logic signed [`RESULT_W-1:0] acc_next;
    logic                        take;
    logic                        win_end;
    logic                        cmd_end;

    assign take    = armed && i_sample_we;
    assign win_end = (samp_cnt == i_win_len - 1'b1);
    assign cmd_end = (win_cnt == i_win_count - 1'b1);

    // Signed product, sign-extended to accumulator width
    assign prod = $signed(i_sample) * $signed(i_weight);
    // First sample of a window restarts from the bias
    assign base     = (samp_cnt == '0) ? $signed(i_bias) : acc;
    assign acc_next = base + prod;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed       <= 1'b0;
            samp_cnt    <= '0;
            win_cnt     <= '0;
            o_result_we <= 1'b0;
            o_last      <= 1'b0;
        end else begin
            o_result_we <= 1'b0;
            o_last      <= 1'b0;
            if (i_start) begin
                armed    <= 1'b1;
                samp_cnt <= '0;
                win_cnt  <= '0;
            end else if (take) begin
                if (win_end) begin
                    samp_cnt    <= '0;
                    win_cnt     <= win_cnt + 1'b1;
                    o_result_we <= 1'b1;
                    o_last      <= cmd_end;
                    // Disarm after the final window
                    if (cmd_end) begin
                        armed <= 1'b0;
                    end
                end else begin
                    samp_cnt <= samp_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc <= acc_next;
            if (win_end) begin
                o_sum <= acc_next;
            end
        end
    end

endmodule

// ==== logic/pool_window_engine.sv ====
`include "layer_consts.svh"

module pool_window_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_start,
    input  logic [`FIELD_W-1:0]  i_win_len,
    input  logic [`FIELD_W-1:0]  i_win_count,
    input  logic [`SHIFT_W-1:0]  i_pool_shift,
    input  logic                 i_sample_we,
    input  logic [`SAMPLE_W-1:0] i_sample,
    output logic                 o_result_we,
    output logic [`RESULT_W-1:0] o_max,
    output logic [`RESULT_W-1:0] o_avg
);

    logic                        armed;
    logic [`FIELD_W-1:0]         samp_cnt;
    logic [`FIELD_W-1:0]         win_cnt;
    logic signed [`SAMPLE_W-1:0] samp;
    logic signed [`RESULT_W-1:0] samp_ext;
    logic signed [`SAMPLE_W-1:0] max_q;
    logic signed [`SAMPLE_W-1:0] max_next;
    logic signed [`RESULT_W-1:0] sum_q;
    logic signed [`RESULT_W-1:0] sum_next;
    logic                        take;
    logic                        first;
    logic                        win_end;
    logic                        cmd_end;

    assign take     = armed && i_sample_we;
    assign first    = (samp_cnt == '0);
    assign win_end  = (samp_cnt == i_win_len - 1'b1);
    assign cmd_end  = (win_cnt == i_win_count - 1'b1);
    assign samp     = $signed(i_sample);
    assign samp_ext = samp;

    // Running signed max and sum, both restart on a window's first sample
    assign max_next = (first || (samp > max_q)) ? samp : max_q;
    assign sum_next = first ? samp_ext : sum_q + samp_ext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed       <= 1'b0;
            samp_cnt    <= '0;
            win_cnt     <= '0;
            o_result_we <= 1'b0;
        end else begin
            o_result_we <= 1'b0;
            if (i_start) begin
                armed    <= 1'b1;
                samp_cnt <= '0;
                win_cnt  <= '0;
            end else if (take) begin
                if (win_end) begin
                    samp_cnt    <= '0;
                    win_cnt     <= win_cnt + 1'b1;
                    o_result_we <= 1'b1;
                    if (cmd_end) begin
                        armed <= 1'b0;
                    end
                end else begin
                    samp_cnt <= samp_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            max_q <= max_next;
            sum_q <= sum_next;
            if (win_end) begin
                o_max <= {{(`RESULT_W - `SAMPLE_W){max_next[`SAMPLE_W-1]}}, max_next};
                // Arithmetic shift keeps negative averages negative
                o_avg <= sum_next >>> i_pool_shift;
            end
        end
    end

endmodule

// ==== logic/result_combiner.sv ====
`include "layer_consts.svh"

module result_combiner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_start,
    input  layer_pkg::op_kind_e  i_op,
    input  logic [`RESULT_W-1:0] i_base_addr,
    input  logic                 i_mac_we,
    input  logic [`RESULT_W-1:0] i_mac_sum,
    input  logic                 i_mac_last,
    input  logic [`RESULT_W-1:0] i_pool_max,
    input  logic [`RESULT_W-1:0] i_pool_avg,
    output logic                 o_result_we,
    output logic [`RESULT_W-1:0] o_result,
    output logic [`RESULT_W-1:0] o_result_addr,
    output logic                 o_cmd_done
);

    layer_pkg::op_kind_e   op_q;
    logic [`RESULT_W-1:0]  base_q;
    logic [`FIELD_W-1:0]   win_idx;
    logic [`RESULT_W-1:0]  win_off;
    logic [`RESULT_W-1:0]  sel;

    // Word addressing, four bytes per result
    assign win_off = {{(`RESULT_W - `FIELD_W - 2){1'b0}}, win_idx, 2'b00};

    always_comb begin
        case (op_q)
            // ReLU clamps negative sums to zero
            layer_pkg::OP_CONV_RELU: sel = i_mac_sum[`RESULT_W-1] ? '0 : i_mac_sum;
            layer_pkg::OP_MAX_POOL:  sel = i_pool_max;
            layer_pkg::OP_AVG_POOL:  sel = i_pool_avg;
            default:                 sel = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_q        <= layer_pkg::OP_IDLE;
            win_idx     <= '0;
            o_result_we <= 1'b0;
            o_cmd_done  <= 1'b0;
        end else begin
            o_result_we <= 1'b0;
            o_cmd_done  <= 1'b0;
            if (i_start) begin
                op_q    <= i_op;
                win_idx <= '0;
            end else if (i_mac_we) begin
                win_idx     <= win_idx + 1'b1;
                o_result_we <= 1'b1;
                // Done goes out with the last result of the command
                o_cmd_done  <= i_mac_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            base_q <= i_base_addr;
        end
        if (i_mac_we) begin
            o_result      <= sel;
            o_result_addr <= base_q + win_off;
        end
    end

endmodule

// ==== logic/layer_ctrl_top.sv ====
`include "layer_consts.svh"

module layer_ctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_op_en,
    input  logic [`CMD_COUNT_W-1:0] i_cmd_count,
    input  logic                    i_cmd_we,
    input  logic [`CMD_W-1:0]       i_cmd,
    input  logic                    i_sample_we,
    input  logic [`SAMPLE_W-1:0]    i_sample,
    input  logic [`SAMPLE_W-1:0]    i_weight,
    output logic                    o_cmd_rd_en,
    output logic                    o_result_we,
    output logic [`RESULT_W-1:0]    o_result,
    output logic [`RESULT_W-1:0]    o_result_addr,
    output logic                    o_irq
);

    // Latched command fields and start strobe
    logic                  start;
    layer_pkg::op_kind_e   op;
    logic [`SHIFT_W-1:0]   pool_shift;
    logic [`FIELD_W-1:0]   win_len;
    logic [`FIELD_W-1:0]   win_count;
    logic [`RESULT_W-1:0]  base_addr;
    logic [`RESULT_W-1:0]  bias;
    // Engine results
    logic                  mac_we;
    logic [`RESULT_W-1:0]  mac_sum;
    logic                  mac_last;
    logic [`RESULT_W-1:0]  pool_max;
    logic [`RESULT_W-1:0]  pool_avg;
    logic                  cmd_done;

    cmd_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .i_op_en      (i_op_en),
        .i_cmd_count  (i_cmd_count),
        .i_cmd_we     (i_cmd_we),
        .i_cmd        (i_cmd),
        .i_cmd_done   (cmd_done),
        .o_cmd_rd_en  (o_cmd_rd_en),
        .o_start      (start),
        .o_op         (op),
        .o_pool_shift (pool_shift),
        .o_win_len    (win_len),
        .o_win_count  (win_count),
        .o_base_addr  (base_addr),
        .o_bias       (bias),
        .o_irq        (o_irq)
    );

    mac_window_engine u_mac (
        .clk         (clk),
        .rst         (rst),
        .i_start     (start),
        .i_win_len   (win_len),
        .i_win_count (win_count),
        .i_bias      (bias),
        .i_sample_we (i_sample_we),
        .i_sample    (i_sample),
        .i_weight    (i_weight),
        .o_result_we (mac_we),
        .o_sum       (mac_sum),
        .o_last      (mac_last)
    );

    // Pool strobe matches the MAC strobe, combiner follows the MAC one
    pool_window_engine u_pool (
        .clk          (clk),
        .rst          (rst),
        .i_start      (start),
        .i_win_len    (win_len),
        .i_win_count  (win_count),
        .i_pool_shift (pool_shift),
        .i_sample_we  (i_sample_we),
        .i_sample     (i_sample),
        .o_result_we  (),
        .o_max        (pool_max),
        .o_avg        (pool_avg)
    );

    result_combiner u_comb (
        .clk           (clk),
        .rst           (rst),
        .i_start       (start),
        .i_op          (op),
        .i_base_addr   (base_addr),
        .i_mac_we      (mac_we),
        .i_mac_sum     (mac_sum),
        .i_mac_last    (mac_last),
        .i_pool_max    (pool_max),
        .i_pool_avg    (pool_avg),
        .o_result_we   (o_result_we),
        .o_result      (o_result),
        .o_result_addr (o_result_addr),
        .o_cmd_done    (cmd_done)
    );

endmodule

// ==== bench/layer_ctrl_checker.sv ====
`include "layer_consts.svh"

module layer_ctrl_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CMD_COUNT_W-1:0] i_cmd_count,
    input  logic                    i_cmd_we,
    input  logic [`CMD_W-1:0]       i_cmd,
    input  logic                    i_cmd_rd_en,
    input  logic                    i_sample_we,
    input  logic [`SAMPLE_W-1:0]    i_sample,
    input  logic [`SAMPLE_W-1:0]    i_weight,
    input  logic                    i_result_we,
    input  logic [`RESULT_W-1:0]    i_result,
    input  logic [`RESULT_W-1:0]    i_result_addr,
    input  logic                    i_irq,
    output int                      o_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // Samples and weights of the window being collected
    byte          win_s [256];
    byte          win_w [256];
    // Expected results in window order and the cycle each is due
    logic [31:0]  exp_val [$];
    logic [31:0]  exp_addr [$];
    longint       exp_cyc [$];
    longint       cyc;
    int           word_idx;
    int           samp_idx;
    int           win_idx;
    int           cmd_seen;
    logic         active;
    logic [2:0]   cur_op;
    logic [3:0]   cur_shift;
    int           cur_len;
    int           cur_cnt;
    logic [31:0]  cur_base;
    logic [31:0]  cur_bias;

    // Expected window result over the stored samples
    function automatic logic [31:0] ref_window(input logic [2:0] op, input logic [3:0] shift,
                                               input logic [31:0] bias, input int len);
        int acc;
        int peak;
        int total;
        acc   = bias;
        peak  = win_s[0];
        total = 0;
        for (int k = 0; k < len; k++) begin
            acc   += int'(win_s[k]) * int'(win_w[k]);
            total += win_s[k];
            if (win_s[k] > peak) begin
                peak = win_s[k];
            end
        end
        case (op)
            // ReLU on bias plus products
            layer_pkg::OP_CONV_RELU: return (acc < 0) ? 32'd0 : acc;
            layer_pkg::OP_MAX_POOL:  return peak;
            default:                 return total >>> shift;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_val.delete();
            exp_addr.delete();
            exp_cyc.delete();
            cyc       = 0;
            word_idx  = 0;
            samp_idx  = 0;
            win_idx   = 0;
            cmd_seen  = 0;
            active    = 1'b0;
            o_errors  = 0;
        end else begin
            cyc = cyc + 1;
            // Result port against the head of the queue
            if (i_result_we) begin
                if (exp_val.size() == 0) begin
                    $display("Unexpected result at address %h with no window pending",
                             i_result_addr);
                    o_errors++;
                end else begin
                    if (i_result !== exp_val[0]) begin
                        $display("FAIL o_result got %h expected %h", i_result, exp_val[0]);
                        o_errors++;
                    end
                    if (i_result_addr !== exp_addr[0]) begin
                        $display("FAIL o_result_addr got %h expected %h",
                                 i_result_addr, exp_addr[0]);
                        o_errors++;
                    end
                    if (cyc != exp_cyc[0]) begin
                        $display("Result for address %h came at cycle %0d instead of %0d",
                                 exp_addr[0], cyc, exp_cyc[0]);
                        o_errors++;
                    end
                    void'(exp_val.pop_front());
                    void'(exp_addr.pop_front());
                    void'(exp_cyc.pop_front());
                end
            end else if ((exp_cyc.size() > 0) && (exp_cyc[0] <= cyc)) begin
                $display("Result for address %h did not arrive on time", exp_addr[0]);
                o_errors++;
                void'(exp_val.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_cyc.pop_front());
            end

            // Command words only count while the read enable is up
            if (i_cmd_we && i_cmd_rd_en) begin
                case (word_idx)
                    0: begin
                        cur_op    = i_cmd[`OP_MSB:`OP_LSB];
                        cur_shift = i_cmd[`SHIFT_MSB:`SHIFT_LSB];
                        cur_len   = int'(i_cmd[`WIN_LEN_MSB:`WIN_LEN_LSB]);
                        cur_cnt   = int'(i_cmd[`WIN_CNT_MSB:`WIN_CNT_LSB]);
                    end
                    1: cur_base = i_cmd;
                    default: begin
                        cur_bias = i_cmd;
                        cmd_seen++;
                        samp_idx = 0;
                        win_idx  = 0;
                        // Skipped commands expect no samples at all
                        active   = (cur_op inside {layer_pkg::OP_CONV_RELU,
                                                   layer_pkg::OP_MAX_POOL,
                                                   layer_pkg::OP_AVG_POOL})
                                   && (cur_len != 0) && (cur_cnt != 0);
                    end
                endcase
                word_idx = (word_idx == `CMD_WORDS - 1) ? 0 : word_idx + 1;
            end

            if (i_sample_we) begin
                if (!active) begin
                    $display("Sample strobed while no command is armed");
                    o_errors++;
                end else begin
                    win_s[samp_idx] = i_sample;
                    win_w[samp_idx] = i_weight;
                    samp_idx++;
                    // Result due two cycles after the window's last sample
                    if (samp_idx == cur_len) begin
                        exp_val.push_back(ref_window(cur_op, cur_shift, cur_bias, cur_len));
                        exp_addr.push_back(cur_base + 32'(4 * win_idx));
                        exp_cyc.push_back(cyc + 2);
                        samp_idx = 0;
                        win_idx++;
                        if (win_idx == cur_cnt) begin
                            active = 1'b0;
                        end
                    end
                end
            end

            // Interrupt only once every command and result is through
            if (i_irq && ((cmd_seen < int'(i_cmd_count)) || active
                          || (exp_val.size() != 0))) begin
                $display("Interrupt raised while commands or results were outstanding");
                o_errors++;
            end
            if (i_irq && i_cmd_rd_en) begin
                $display("Command read enable high after the interrupt");
                o_errors++;
            end
        end
    end

endmodule

// ==== bench/layer_ctrl_tb.sv ====
`include "layer_consts.svh"

module layer_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CMDS = 5;
    // Five commands covering conv, max, avg, idle and conv with negative bias
    localparam logic [2:0] CMD_OP [NUM_CMDS] = '{layer_pkg::OP_CONV_RELU,
        layer_pkg::OP_MAX_POOL, layer_pkg::OP_AVG_POOL, layer_pkg::OP_IDLE,
        layer_pkg::OP_CONV_RELU};
    localparam int          CMD_LEN  [NUM_CMDS] = '{4, 5, 4, 3, 3};
    localparam int          CMD_CNT  [NUM_CMDS] = '{3, 2, 3, 2, 4};
    localparam logic [31:0] CMD_BASE [NUM_CMDS] = '{32'h1000, 32'h2000, 32'h3000,
                                                    32'h4000, 32'h5000};

    logic                    clk;
    logic                    rst;
    logic                    i_op_en;
    logic [`CMD_COUNT_W-1:0] i_cmd_count;
    logic                    i_cmd_we;
    logic [`CMD_W-1:0]       i_cmd;
    logic                    i_sample_we;
    logic [`SAMPLE_W-1:0]    i_sample;
    logic [`SAMPLE_W-1:0]    i_weight;
    logic                    o_cmd_rd_en;
    logic                    o_result_we;
    logic [`RESULT_W-1:0]    o_result;
    logic [`RESULT_W-1:0]    o_result_addr;
    logic                    o_irq;
    logic [15:0]             lfsr;
    int                      cycles;
    int                      limit;
    int                      chk_errors;

    layer_ctrl_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .i_op_en       (i_op_en),
        .i_cmd_count   (i_cmd_count),
        .i_cmd_we      (i_cmd_we),
        .i_cmd         (i_cmd),
        .i_sample_we   (i_sample_we),
        .i_sample      (i_sample),
        .i_weight      (i_weight),
        .o_cmd_rd_en   (o_cmd_rd_en),
        .o_result_we   (o_result_we),
        .o_result      (o_result),
        .o_result_addr (o_result_addr),
        .o_irq         (o_irq)
    );

    layer_ctrl_checker chk_i (
        .clk           (clk),
        .rst           (rst),
        .i_cmd_count   (i_cmd_count),
        .i_cmd_we      (i_cmd_we),
        .i_cmd         (i_cmd),
        .i_cmd_rd_en   (o_cmd_rd_en),
        .i_sample_we   (i_sample_we),
        .i_sample      (i_sample),
        .i_weight      (i_weight),
        .i_result_we   (o_result_we),
        .i_result      (o_result),
        .i_result_addr (o_result_addr),
        .i_irq         (o_irq),
        .o_errors      (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit from the length of the command list
    always @(posedge clk) begin
        cycles++;
        if ((limit > 0) && (cycles > limit)) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Galois LFSR x^16+x^14+x^13+x^11+1 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        out;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            out  = lfsr[0];
            lfsr = lfsr >> 1;
            if (out) begin
                lfsr = lfsr ^ 16'hB400;
            end
            bits = {bits[30:0], out};
        end
        return bits;
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic step_clock();
        @(posedge clk);
        #2;
    endtask

    task automatic send_command(input int c);
        logic [31:0] word0;
        logic [31:0] bias;
        logic [3:0]  shift;
        shift = 4'(take_bits(2));
        // Last command gets a negative bias so some windows clamp
        if (c == NUM_CMDS - 1) begin
            bias = 32'd0 - take_bits(8) - 32'd60;
        end else begin
            bias = take_bits(6);
        end
        word0 = {8'h00, 8'(CMD_CNT[c]), 8'(CMD_LEN[c]), shift, 1'b0, CMD_OP[c]};
        while (!o_cmd_rd_en) begin
            step_clock();
        end
        i_cmd_we = 1'b1;
        i_cmd    = word0;
        step_clock();
        i_cmd = CMD_BASE[c];
        step_clock();
        i_cmd = bias;
        step_clock();
        i_cmd_we = 1'b0;
    endtask

    task automatic send_samples(input int c);
        repeat (4) begin
            step_clock();
        end
        for (int k = 0; k < CMD_LEN[c] * CMD_CNT[c]; k++) begin
            i_sample_we = 1'b1;
            i_sample    = 8'(take_bits(8));
            i_weight    = 8'(take_bits(8));
            step_clock();
            i_sample_we = 1'b0;
            // Occasional gap cycle
            if (take_bits(2) == 0) begin
                step_clock();
            end
        end
    endtask

    initial begin
        lfsr         = 16'd56;
        cycles       = 0;
        limit        = 0;
        for (int c = 0; c < NUM_CMDS; c++) begin
            limit += `CMD_WORDS + 4 + CMD_LEN[c] * CMD_CNT[c] + 4;
        end
        limit        = 2 * limit + 50;
        rst          = 1'b1;
        i_op_en      = 1'b0;
        i_cmd_count  = `CMD_COUNT_W'(NUM_CMDS);
        i_cmd_we     = 1'b0;
        i_cmd        = '0;
        i_sample_we  = 1'b0;
        i_sample     = '0;
        i_weight     = '0;
        repeat (4) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b0;
        step_clock();
        i_op_en = 1'b1;
        for (int c = 0; c < NUM_CMDS; c++) begin
            send_command(c);
            if (CMD_OP[c] != layer_pkg::OP_IDLE) begin
                send_samples(c);
            end
        end
        // Interrupt follows the last result
        while (!o_irq) begin
            step_clock();
        end
        repeat (4) begin
            step_clock();
        end
        $display("Checker errors %0d", chk_errors);
        if (chk_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== layer_ctrl_top.f ====
+incdir+include
logic/layer_pkg.sv
logic/cmd_sequencer.sv
logic/mac_window_engine.sv
logic/pool_window_engine.sv
logic/result_combiner.sv
logic/layer_ctrl_top.sv
bench/layer_ctrl_checker.sv
bench/layer_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the layer controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f layer_ctrl_top.f \
    --top-module layer_ctrl_tb -Mdir obj_dir -o layer_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/layer_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
exit 1
